// File: all.f
src/read_master_pkg.sv
src/read_control.sv
src/transfer_counter.sv
src/pending_reads.sv
src/packet_tagger.sv
src/stream_fifo.sv
src/read_master_top.sv
verif/read_master_sva.sv
verif/read_master_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the read master testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module read_master_tb \
  -f all.f -o read_master_sim \
  && ./obj_dir/read_master_sim | tee sim.log \
  && grep -q "^Test OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: verif/read_master_tb.sv
//**************************************************************************
// testbench of the memory read master, one descriptor row after another
// memory word at byte address a is (a * 32'h0001_0003) ^ 32'h6B2D_91E7
// only aligned lengths that are multiples of the word size are driven
// a watchdog ends the run if a transfer or a drain never completes
//**************************************************************************
`timescale 1ns/10ps

module read_master_tb
  import read_master_pkg::*;
();

  localparam int DATA_WIDTH = 32;
  localparam int FIFO_DEPTH = 32;
  localparam int MAX_BURST = 4;
  localparam int WORD_BYTES = DATA_WIDTH / SYMBOL_WIDTH;
  localparam logic [1:0] ACT_NONE = 2'd0;
  localparam logic [1:0] ACT_STOP = 2'd1;
  localparam logic [1:0] ACT_RESET = 2'd2;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] address;
    logic [LEN_WIDTH-1:0] length;
    logic sop;
    logic eop;
    logic early;
    logic bp;                       // random waitrequest and src_ready
    logic [1:0] action;             // software stop or reset raised mid transfer
  } row_t;

  logic clk = 1'b0;
  logic reset;
  descriptor_t cmd;
  logic cmd_valid;
  logic cmd_ready;
  sw_control_t sw;
  response_t resp;
  logic resp_valid;
  logic resp_ready;
  status_t status;
  logic [ADDR_WIDTH-1:0] mem_address;
  logic mem_read;
  logic [$clog2(MAX_BURST):0] mem_burstcount;
  logic mem_waitrequest = 1'b0;
  logic [DATA_WIDTH-1:0] mem_readdata = '0;
  logic mem_readdatavalid = 1'b0;
  logic [DATA_WIDTH-1:0] src_data;
  logic src_sop;
  logic src_eop;
  logic src_valid;
  logic src_ready = 1'b1;

  row_t rows[$];
  string names[$];
  string cur_name = "reset_values";
  logic [DATA_WIDTH+1:0] got[$];              // {sop, eop, data} of each streamed word
  logic [ADDR_WIDTH-1:0] burst_addr[$];       // accepted bursts waiting to be answered
  int burst_len[$];
  logic [ADDR_WIDTH-1:0] ret_addr;
  int ret_left = 0;
  int ret_delay = 0;
  int bursts_accepted = 0;
  int resp_pops = 0;
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int limit_cycles = 0;
  logic bp_on = 1'b0;
  int ready_mode = 0;                         // 0 keeps src_ready high, 1 random, 2 held low

  read_master_top #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH), .MAX_BURST(MAX_BURST))
    dut0 (.*);

  always #20 clk = ~clk;                      // 40 ns period

  function automatic logic [DATA_WIDTH-1:0] mem_word(input logic [ADDR_WIDTH-1:0] a);
    return (a * 32'h0001_0003) ^ 32'h6B2D_91E7;
  endfunction

  // the first byte in memory becomes the top byte of the stream word
  function automatic logic [DATA_WIDTH-1:0] swap_symbols(input logic [DATA_WIDTH-1:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual)
    begin
      errors++;
      $display("error %s %s: expected %h, actual %h", cur_name, what, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input logic [31:0] address, input int length,
                         input logic sop, input logic eop, input logic early,
                         input logic bp, input logic [1:0] action);
    rows.push_back('{address: address, length: length, sop: sop, eop: eop,
                     early: early, bp: bp, action: action});
    names.push_back(name);
  endtask

  task automatic report_test(input int errors_before);
    if (errors == errors_before)
    begin
      tests_passed++;
      $display("test %s passed", cur_name);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed", cur_name);
    end
  endtask

  task automatic send_command(input row_t row);
    @(posedge clk);
    cmd <= '{address: row.address, length: row.length, generate_sop: row.sop,
             generate_eop: row.eop, early_done_enable: row.early};
    cmd_valid <= 1'b1;
    do
      @(posedge clk);
    while (!cmd_ready);                       // descriptor is taken on this edge
    cmd_valid <= 1'b0;
    cmd <= '0;
  endtask

  task automatic wait_bursts(input int target);
    while (bursts_accepted < target)
      @(negedge clk);
  endtask

  task automatic run_row(input int r);
    row_t row;
    response_t expect_resp;
    logic [DATA_WIDTH+1:0] w;
    int n;
    int errors_before;
    row = rows[r];
    cur_name = names[r];
    n = int'(row.length) / WORD_BYTES;
    errors_before = errors;
    @(negedge clk);
    got.delete();
    resp_pops = 0;
    bp_on = row.bp;
    ready_mode = row.early ? 2 : (row.bp ? 1 : 0);
    send_command(row);
    @(negedge clk);
    check("cmd_ready after go", 0, cmd_ready);
    if (row.action != ACT_NONE)
    begin
      wait_bursts(bursts_accepted + 2);       // let two bursts go out first
      @(posedge clk);
      if (row.action == ACT_STOP)
        sw.stop <= 1'b1;
      else
        sw.reset <= 1'b1;
      do
        @(negedge clk);
      while (!(row.action == ACT_STOP ? status.stopped : status.flushing));
      if (row.action == ACT_STOP)
      begin
        repeat (20)
        begin
          @(negedge clk);
          check("mem_read while stopped", 0, mem_read);
        end
      end
      @(posedge clk);
      sw <= '0;
    end
    do
    begin
      @(negedge clk);
      check("cmd_ready before response", 0, cmd_ready);
    end
    while (!resp_valid);
    expect_resp = '{done: 1'b1, early_done: 1'b1, stopped: 1'b0,
                    flushed: (row.action == ACT_RESET)};
    check("response", expect_resp, resp);
    if (row.early)
      check("words in FIFO at early done", 1, got.size() + int'(dut0.u_fifo.used) < n);
    else if (row.action != ACT_RESET)
      check("words in FIFO at response", n, got.size() + int'(dut0.u_fifo.used));
    ready_mode = row.bp ? 1 : 0;              // release the held stream
    @(posedge clk);
    resp_ready <= 1'b1;
    @(posedge clk);
    resp_ready <= 1'b0;                       // response is popped on this edge
    if (row.action == ACT_RESET)
    begin
      do
        @(negedge clk);
      while (src_valid);                      // flushed words still in the FIFO drain out
      check("flushed words fewer than length", 1, got.size() < n);
    end
    else
    begin
      do
        @(negedge clk);
      while (got.size() < n);
      check("extra stream word", 0, src_valid);
      check("word count", n, got.size());
    end
    for (int i = 0; i < got.size(); i++)
    begin
      w = got[i];
      check($sformatf("word %0d data", i), swap_symbols(mem_word(row.address + 4 * i)),
            w[DATA_WIDTH-1:0]);
      check($sformatf("word %0d sop", i), row.sop && i == 0, w[DATA_WIDTH+1]);
      check($sformatf("word %0d eop", i), row.eop && i == n - 1, w[DATA_WIDTH]);
    end
    check("response count", 1, resp_pops);
    check("resp_valid after pop", 0, resp_valid);
    report_test(errors_before);
  endtask

  // waitrequest and src_ready are random only where the row asks for it
  always @(posedge clk)
  begin
    mem_waitrequest <= bp_on & ($urandom_range(0, 1) == 1);
    case (ready_mode)
      1: src_ready <= ($urandom_range(0, 3) != 0);
      2: src_ready <= 1'b0;
      default: src_ready <= 1'b1;
    endcase
  end

  // the memory model answers bursts in order after a random latency
  always @(posedge clk)
  begin
    if (mem_read && !mem_waitrequest)
    begin
      burst_addr.push_back(mem_address);
      burst_len.push_back(int'(mem_burstcount));
      bursts_accepted++;
    end
    mem_readdatavalid <= 1'b0;
    if (ret_left == 0 && burst_addr.size() != 0)
    begin
      ret_addr = burst_addr.pop_front();
      ret_left = burst_len.pop_front();
      ret_delay = $urandom_range(1, 4);       // cycles before the first word of a burst
    end
    if (ret_left != 0 && ret_delay != 0)
      ret_delay--;
    else if (ret_left != 0)
    begin
      mem_readdata <= mem_word(ret_addr);
      mem_readdatavalid <= 1'b1;
      ret_addr = ret_addr + 32'(WORD_BYTES);
      ret_left--;
    end
  end

  // stream words and response pops as they are taken by the sink
  always @(posedge clk)
  begin
    if (src_valid && src_ready)
      got.push_back({src_sop, src_eop, src_data});
    if (resp_valid && resp_ready)
      resp_pops++;
  end

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, a transfer never finished", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(32'h0537_b517));
    reset = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    sw = '0;
    resp_ready = 1'b0;
    add_row("single_word", 32'h0000_0100, 4, 1'b1, 1'b1, 1'b0, 1'b0, ACT_NONE);
    add_row("partial_burst", 32'h0000_0200, 12, 1'b1, 1'b0, 1'b0, 1'b0, ACT_NONE);
    add_row("multi_burst", 32'h0000_1000, 40, 1'b0, 1'b1, 1'b0, 1'b0, ACT_NONE);
    add_row("backpressure", 32'h0000_2000, 256, 1'b1, 1'b1, 1'b0, 1'b1, ACT_NONE);
    add_row("early_done", 32'h0000_3000, 64, 1'b1, 1'b1, 1'b1, 1'b0, ACT_NONE);
    add_row("stop_resume", 32'h0000_4000, 128, 1'b1, 1'b1, 1'b0, 1'b0, ACT_STOP);
    add_row("software_reset", 32'h0000_5000, 256, 1'b1, 1'b1, 1'b0, 1'b0, ACT_RESET);
    add_row("after_flush", 32'h0000_6000, 32, 1'b1, 1'b1, 1'b0, 1'b0, ACT_NONE);
    foreach (rows[i])
      limit_cycles += int'(rows[i].length) / WORD_BYTES * 40;
    limit_cycles += 2000;                     // reset and response overhead
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("cmd_ready", 1, cmd_ready);
    check("resp_valid", 0, resp_valid);
    check("mem_read", 0, mem_read);
    check("src_valid", 0, src_valid);
    check("status", 0, status);
    report_test(0);
    foreach (rows[i])
      run_row(i);
    errors += dut0.u_sva.assert_failures;
    $display("%0d tests passed, %0d tests failed, %0d errors", tests_passed, tests_failed,
             errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

// File: verif/read_master_sva.sv
//**************************************************************************
// concurrent checks on read issue and flow control of the read master
// bound into read_master_top, where the memory port and headroom flag meet
// all checks are off while reset is high
//**************************************************************************
`timescale 1ns/10ps

module read_master_sva
  import read_master_pkg::*;
#(
  parameter int MAX_BURST = 4
)
(
  input logic clk,
  input logic reset,
  input logic mem_read,
  input logic mem_waitrequest,
  input logic [ADDR_WIDTH-1:0] mem_address,
  input logic [$clog2(MAX_BURST):0] mem_burstcount,
  input logic too_many_pending,
  input status_t status
);

  int assert_failures = 0;     // read by the testbench at the end of the run

  // a new read may only start while FIFO plus pending words are under the limit
  read_in_headroom: assert property (@(posedge clk) disable iff (reset)
    $rose(mem_read) |-> !$past(too_many_pending))
  else
  begin
    assert_failures++;
    $error("mem_read rose while the headroom limit was exceeded");
  end

  // a read held by waitrequest keeps its address and burst count
  read_held_stable: assert property (@(posedge clk) disable iff (reset)
    mem_read && mem_waitrequest |=> mem_read && $stable(mem_address) && $stable(mem_burstcount))
  else
  begin
    assert_failures++;
    $error("read request changed while waitrequest held it");
  end

  // no read goes out while the master reports itself stopped
  no_read_stopped: assert property (@(posedge clk) disable iff (reset)
    status.stopped |-> !mem_read)
  else
  begin
    assert_failures++;
    $error("mem_read was high while stopped");
  end

endmodule

bind read_master_top read_master_sva #(.MAX_BURST(MAX_BURST)) u_sva (
  .clk(clk), .reset(reset), .mem_read(mem_read), .mem_waitrequest(mem_waitrequest),
  .mem_address(mem_address), .mem_burstcount(mem_burstcount),
  .too_many_pending(too_many_pending), .status(status)
);

// File: src/read_master_top.sv
//**************************************************************************
// memory read master, descriptor in, burst reads out, stream of words back
// FIFO_DEPTH must be a power of two and at least four times MAX_BURST
// only aligned full-word transfers are supported
//**************************************************************************
`timescale 1ns/10ps

module read_master_top
  import read_master_pkg::*;
#(
  parameter int DATA_WIDTH = 32,   // multiple of SYMBOL_WIDTH
  parameter int FIFO_DEPTH = 32,   // power of two
  parameter int MAX_BURST = 4      // power of two
)
(
  input  logic clk,
  input  logic reset,
  input  descriptor_t cmd,
  input  logic cmd_valid,
  output logic cmd_ready,
  input  sw_control_t sw,
  output response_t resp,
  output logic resp_valid,
  input  logic resp_ready,
  output status_t status,
  output logic [ADDR_WIDTH-1:0] mem_address,
  output logic mem_read,
  output logic [$clog2(MAX_BURST):0] mem_burstcount,
  input  logic mem_waitrequest,
  input  logic [DATA_WIDTH-1:0] mem_readdata,
  input  logic mem_readdatavalid,
  output logic [DATA_WIDTH-1:0] src_data,
  output logic src_sop,
  output logic src_eop,
  output logic src_valid,
  input  logic src_ready
);

  logic go;                                  // descriptor accepted this cycle
  logic flush;                               // software reset in progress
  logic flush_clear;                         // flush with nothing left in flight
  logic read_complete;                       // burst read accepted by memory
  logic done;                                // no bytes left to request
  logic too_many_pending;
  logic pending_zero;
  logic [DATA_WIDTH-1:0] wr_data;
  logic wr_sop;
  logic wr_eop;
  logic wr_en;
  logic [$clog2(FIFO_DEPTH):0] fifo_used;

  assign read_complete = mem_read & ~mem_waitrequest;
  assign flush_clear = flush & pending_zero;

  read_control u_control (
    .clk(clk), .reset(reset),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .early_done_enable(cmd.early_done_enable),
    .sw(sw), .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready), .status(status),
    .go(go), .mem_read(mem_read), .mem_waitrequest(mem_waitrequest),
    .done(done), .too_many_pending(too_many_pending), .pending_zero(pending_zero),
    .flush(flush)
  );

  transfer_counter #(.DATA_WIDTH(DATA_WIDTH), .MAX_BURST(MAX_BURST)) u_counter (
    .clk(clk), .reset(reset),
    .go(go), .cmd(cmd), .read_complete(read_complete), .flush_clear(flush_clear),
    .mem_address(mem_address), .mem_burstcount(mem_burstcount), .done(done)
  );

  pending_reads #(.FIFO_DEPTH(FIFO_DEPTH), .MAX_BURST(MAX_BURST)) u_pending (
    .clk(clk), .reset(reset),
    .read_complete(read_complete), .burstcount(mem_burstcount),
    .readdatavalid(mem_readdatavalid), .fifo_used(fifo_used),
    .too_many_pending(too_many_pending), .pending_zero(pending_zero)
  );

  packet_tagger #(.DATA_WIDTH(DATA_WIDTH)) u_tagger (
    .clk(clk), .reset(reset),
    .go(go), .cmd(cmd), .flush(flush),
    .readdata(mem_readdata), .readdatavalid(mem_readdatavalid),
    .wr_data(wr_data), .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_en(wr_en)
  );

  stream_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .reset(reset),
    .wr_data(wr_data), .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_en(wr_en),
    .src_data(src_data), .src_sop(src_sop), .src_eop(src_eop),
    .src_valid(src_valid), .src_ready(src_ready),
    .used(fifo_used)
  );

endmodule

// File: src/stream_fifo.sv
//**************************************************************************
// show-ahead FIFO of stream words with their sop and eop flags
// no overflow guard, the pending read count keeps room for all bursts
//**************************************************************************
`timescale 1ns/10ps

module stream_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 32     // power of two
)
(
  input  logic clk,
  input  logic reset,
  input  logic [DATA_WIDTH-1:0] wr_data,
  input  logic wr_sop,
  input  logic wr_eop,
  input  logic wr_en,
  output logic [DATA_WIDTH-1:0] src_data,
  output logic src_sop,
  output logic src_eop,
  output logic src_valid,
  input  logic src_ready,
  output logic [$clog2(FIFO_DEPTH):0] used
);

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  typedef struct packed {
    logic sop;
    logic eop;
    logic [DATA_WIDTH-1:0] data;
  } entry_t;

  entry_t mem [FIFO_DEPTH];
  entry_t head;                       // oldest entry, visible without a read request
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic rd_en;

  assign head = mem[rd_ptr];
  assign src_data = head.data;
  assign src_sop = head.sop;
  assign src_eop = head.eop;
  assign src_valid = (used != '0);
  assign rd_en = src_valid & src_ready;

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= '{sop: wr_sop, eop: wr_eop, data: wr_data};
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;      // pointers wrap at the power of two depth
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      used <= used + (PTR_WIDTH + 1)'(wr_en) - (PTR_WIDTH + 1)'(rd_en);
    end
  end

endmodule

// File: src/packet_tagger.sv
//**************************************************************************
// registered stage from the memory read data into the stream FIFO
// words are counted per descriptor to place sop and eop
// symbols are reversed into network order, words are dropped while flushing
//**************************************************************************
`timescale 1ns/10ps

module packet_tagger
  import read_master_pkg::*;
#(
  parameter int DATA_WIDTH = 32
)
(
  input  logic clk,
  input  logic reset,
  input  logic go,
  input  descriptor_t cmd,
  input  logic flush,
  input  logic [DATA_WIDTH-1:0] readdata,
  input  logic readdatavalid,
  output logic [DATA_WIDTH-1:0] wr_data,
  output logic wr_sop,
  output logic wr_eop,
  output logic wr_en
);

  localparam int NUM_SYMBOLS = DATA_WIDTH / SYMBOL_WIDTH;
  localparam int WORD_LSBS = $clog2(NUM_SYMBOLS);

  logic sop_en;
  logic eop_en;
  logic [LEN_WIDTH-1:0] word_total;     // words expected for this descriptor
  logic [LEN_WIDTH-1:0] word_count;     // words that have arrived so far
  logic [DATA_WIDTH-1:0] reversed;
  logic accept;

  assign accept = readdatavalid & ~flush;

  // first symbol on the bus goes out in the top symbol lane
  always_comb
  begin
    for (int i = 0; i < NUM_SYMBOLS; i++)
    begin
      reversed[i*SYMBOL_WIDTH +: SYMBOL_WIDTH] =
        readdata[(NUM_SYMBOLS-1-i)*SYMBOL_WIDTH +: SYMBOL_WIDTH];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sop_en <= 1'b0;
      eop_en <= 1'b0;
      word_total <= '0;
      word_count <= '0;
      wr_en <= 1'b0;
      wr_sop <= 1'b0;
      wr_eop <= 1'b0;
    end
    else
    begin
      if (go)
      begin
        sop_en <= cmd.generate_sop;
        eop_en <= cmd.generate_eop;
        word_total <= cmd.length >> WORD_LSBS;
        word_count <= '0;
      end
      else if (accept)
      begin
        word_count <= word_count + 1'b1;
      end
      wr_en <= accept;
      wr_sop <= sop_en & (word_count == '0);
      wr_eop <= eop_en & (word_count == word_total - 1'b1);
    end
  end

  always_ff @(posedge clk)
  begin
    wr_data <= reversed;
  end

endmodule

// File: src/pending_reads.sv
//**************************************************************************
// words requested from memory that have not yet returned
// headroom keeps two full bursts free, since read issue reacts a cycle late
//**************************************************************************
`timescale 1ns/10ps

module pending_reads #(
  parameter int FIFO_DEPTH = 32,
  parameter int MAX_BURST = 4
)
(
  input  logic clk,
  input  logic reset,
  input  logic read_complete,
  input  logic [$clog2(MAX_BURST):0] burstcount,
  input  logic readdatavalid,
  input  logic [$clog2(FIFO_DEPTH):0] fifo_used,
  output logic too_many_pending,
  output logic pending_zero
);

  localparam int CNT_WIDTH = $clog2(FIFO_DEPTH) + 1;
  localparam int LIMIT = FIFO_DEPTH - 2 * MAX_BURST;

  logic [CNT_WIDTH-1:0] pending;
  logic [CNT_WIDTH-1:0] added;         // words of the burst accepted this cycle
  logic [CNT_WIDTH:0] occupancy;       // one bit wider, the sum can pass FIFO_DEPTH

  assign added = read_complete ? CNT_WIDTH'(burstcount) : '0;
  assign occupancy = {1'b0, fifo_used} + {1'b0, pending};
  assign too_many_pending = occupancy > (CNT_WIDTH + 1)'(LIMIT);
  assign pending_zero = (pending == '0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pending <= '0;
    end
    else
    begin
      pending <= pending + added - CNT_WIDTH'(readdatavalid);  // both can happen in one cycle
    end
  end

endmodule

// File: src/transfer_counter.sv
//**************************************************************************
// read address and remaining length of the running transfer
// the address is forced to a word boundary and bursts never cross the end
//**************************************************************************
`timescale 1ns/10ps

module transfer_counter
  import read_master_pkg::*;
#(
  parameter int DATA_WIDTH = 32,
  parameter int MAX_BURST = 4
)
(
  input  logic clk,
  input  logic reset,
  input  logic go,
  input  descriptor_t cmd,
  input  logic read_complete,
  input  logic flush_clear,
  output logic [ADDR_WIDTH-1:0] mem_address,
  output logic [$clog2(MAX_BURST):0] mem_burstcount,
  output logic done
);

  localparam int WORD_BYTES = DATA_WIDTH / SYMBOL_WIDTH;
  localparam int WORD_LSBS = $clog2(WORD_BYTES);
  localparam int BURST_WIDTH = $clog2(MAX_BURST) + 1;

  logic [LEN_WIDTH-1:0] length_q;          // bytes not yet requested
  logic [LEN_WIDTH-1:0] words_left;
  logic [LEN_WIDTH-1:0] burst_bytes;       // bytes covered by the burst being issued

  assign words_left = length_q >> WORD_LSBS;
  assign mem_burstcount = (words_left >= LEN_WIDTH'(MAX_BURST)) ?
                          BURST_WIDTH'(MAX_BURST) : words_left[BURST_WIDTH-1:0];
  assign burst_bytes = LEN_WIDTH'(mem_burstcount) << WORD_LSBS;
  assign done = (length_q == '0);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mem_address <= '0;
    end
    else if (go)
    begin
      mem_address <= cmd.address & ~ADDR_WIDTH'(WORD_BYTES - 1);
    end
    else if (read_complete)
    begin
      mem_address <= mem_address + ADDR_WIDTH'(burst_bytes);
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      length_q <= '0;
    end
    else if (flush_clear)
    begin
      length_q <= '0;                      // forces done so the flushed transfer can answer
    end
    else if (go)
    begin
      length_q <= cmd.length;
    end
    else if (read_complete)
    begin
      length_q <= length_q - burst_bytes;  // same step as the address
    end
  end

endmodule

// File: src/read_control.sv
//**************************************************************************
// command, read issue, stop/flush and response control of the read master
// stop and software reset are levels, sampled only at read boundaries
// a new command waits until no reads are in flight
//**************************************************************************
`timescale 1ns/10ps

module read_control
  import read_master_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic early_done_enable,
  input  sw_control_t sw,
  output response_t resp,
  output logic resp_valid,
  input  logic resp_ready,
  output status_t status,
  output logic go,
  output logic mem_read,
  input  logic mem_waitrequest,
  input  logic done,
  input  logic too_many_pending,
  input  logic pending_zero,
  output logic flush
);

  logic idle_q;           // no transfer owns the master, set again when the response is popped
  logic read_q;           // registered read request before the done mask
  logic early_q;          // early done enable of the running transfer
  logic stopped_q;
  logic flushed_seen;     // sticky per transfer so a held reset level flushes only once
  logic read_complete;
  logic boundary;         // safe point to stop or flush, no read is being held
  logic resp_pop;
  logic done_cond;        // all reads accepted
  logic done_d1;
  logic returned_cond;    // all reads accepted and all words back
  logic returned_d1;
  logic done_strobe;
  logic returned_strobe;
  logic set_resp;

  assign cmd_ready = idle_q & pending_zero & ~flush;     // early done may leave words in flight
  assign go = cmd_valid & cmd_ready;
  assign read_complete = mem_read & ~mem_waitrequest;
  assign mem_read = read_q & ~done;                       // mask keeps an extra read from issuing
  assign boundary = read_complete | idle_q | ~read_q;
  assign resp_pop = resp_valid & resp_ready;
  assign done_cond = done & ~flush;                       // held low while a flush drains
  assign returned_cond = done & pending_zero & ~flush;
  assign done_strobe = done_cond & ~done_d1;
  assign returned_strobe = returned_cond & ~returned_d1;
  assign set_resp = ~idle_q & (early_q ? done_strobe : returned_strobe);
  assign status = '{stopped: stopped_q, flushing: flush};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      idle_q <= 1'b1;                                     // ready for a command out of reset
      early_q <= 1'b0;
      done_d1 <= 1'b1;                                    // idle counts as done, so no strobe fires
      returned_d1 <= 1'b1;
    end
    else
    begin
      if (go)
      begin
        idle_q <= 1'b0;
        early_q <= early_done_enable;
      end
      else if (resp_pop)
      begin
        idle_q <= 1'b1;
      end
      done_d1 <= done_cond;
      returned_d1 <= returned_cond;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      read_q <= 1'b0;
    end
    else if ((go | ~done) & ~too_many_pending & ~sw.stop & ~sw.reset & ~flush)
    begin
      read_q <= 1'b1;                                     // go lets mem_read rise the next cycle
    end
    else if (done | (read_complete & (too_many_pending | sw.stop | sw.reset)))
    begin
      read_q <= 1'b0;                                     // a held read stays until it is accepted
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush <= 1'b0;
      flushed_seen <= 1'b0;
      stopped_q <= 1'b0;
    end
    else
    begin
      if (flush & pending_zero)
      begin
        flush <= 1'b0;                                    // in-flight words have drained
      end
      else if (sw.reset & ~flushed_seen & boundary)
      begin
        flush <= 1'b1;
      end
      if (go)
      begin
        flushed_seen <= 1'b0;
      end
      else if (flush)
      begin
        flushed_seen <= 1'b1;
      end
      if (~sw.stop | sw.reset)
      begin
        stopped_q <= 1'b0;
      end
      else if (boundary)
      begin
        stopped_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      resp_valid <= 1'b0;
    end
    else if (flush)
    begin
      resp_valid <= 1'b0;                                 // the flushed transfer answers once drained
    end
    else if (set_resp)
    begin
      resp_valid <= 1'b1;
    end
    else if (resp_pop)
    begin
      resp_valid <= 1'b0;
    end
  end

  // response word is captured with the strobe and held until popped
  always_ff @(posedge clk)
  begin
    if (set_resp)
    begin
      resp <= '{done: returned_cond | early_q, early_done: done_cond,
                stopped: stopped_q, flushed: flushed_seen};
    end
  end

endmodule

// File: src/read_master_pkg.sv
//**************************************************************************
// shared widths and port structs of the memory read master
// symbols are bytes, so the word size in bytes is DATA_WIDTH / SYMBOL_WIDTH
// descriptor lengths must be non-zero multiples of the word size
//**************************************************************************

package read_master_pkg;

  localparam int ADDR_WIDTH = 32;    // byte address of the memory master port
  localparam int LEN_WIDTH = 32;     // byte length of one transfer
  localparam int SYMBOL_WIDTH = 8;   // one stream symbol, reversed into network order

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] address;  // start address, low bits below the word are ignored
    logic [LEN_WIDTH-1:0] length;    // bytes to read
    logic generate_sop;              // tag the first word with sop
    logic generate_eop;              // tag the last word with eop
    logic early_done_enable;         // respond once the last read is accepted
  } descriptor_t;

  typedef struct packed {
    logic stop;                      // level, halts read issue at the next boundary
    logic reset;                     // level, flushes the current transfer
  } sw_control_t;

  typedef struct packed {
    logic done;                      // transfer finished from the host's point of view
    logic early_done;                // all reads of the transfer were accepted
    logic stopped;                   // master was stopped when the response was formed
    logic flushed;                   // transfer was cut short by a software reset
  } response_t;

  typedef struct packed {
    logic stopped;
    logic flushing;
  } status_t;

endpackage
